// ==== kl10Vma.f ====
hdl/vmaPkg.sv
hdl/vmaAddrPath.sv
hdl/vmaContext.sv
hdl/vmaStatusPort.sv
hdl/vmaUnit.sv
testbench/tbClock.sv
testbench/tbVmaUnit.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbVmaUnit
FILELIST = kl10Vma.f
OBJDIR   = obj_dir
PASSMSG  = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/vmaStim.txt ====
# C mode(ld ua inc cm) magic xe xs pls(lpc lh sh) refs(ext fe pu rw) adSec adOff
#   exp(acRef localAc match) hopSec hopOff      W addr data err      R addr expData err
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 0000000F 0
C 1100 000 0 0 000 0000 03 00123 001 00 00000
R 08 000C0123 0
C 0000 000 0 0 100 0000 00 00000 000 00 00000
R 0C 000C0123 0
C 1001 0FF 0 0 000 0000 00 00000 000 03 00123
R 08 000C0222 0
C 1010 000 0 0 000 0000 00 00000 000 03 00123
R 08 000C0124 0
C 0010 000 0 0 000 0000 00 00000 000 03 00123
R 08 000C0125 0
C 1100 000 0 0 000 0000 03 3FFFF 000 03 00123
C 0010 000 0 0 000 0000 00 00000 000 03 00123
R 08 000C0000 0
C 1100 000 0 0 000 0000 03 3FFF0 010 03 00123
C 0000 000 0 0 100 0000 00 00000 000 03 00123
C 1001 1FF 0 0 000 0000 00 00000 000 03 3FFF0
R 08 000C01EF 0
W 04 00000011 0
R 04 00000011 0
C 0000 000 1 2 000 0000 00 00000 000 03 3FFF0
R 08 004401EF 0
C 0000 000 1 1 000 0000 00 00000 000 03 3FFF0
R 08 000C01EF 0
C 0000 000 1 3 000 0000 1A 00055 000 03 3FFF0
R 08 006801EF 0
C 1100 000 1 0 000 0000 07 00042 000 03 3FFF0
R 08 00680042 0
C 0000 000 0 0 010 0000 00 00000 000 03 3FFF0
R 10 00680042 0
C 0000 000 0 0 001 0000 00 00000 000 1A 00042
C 0000 000 0 0 000 0000 00 00000 000 03 3FFF0
C 1100 000 0 0 000 0000 05 00007 000 03 3FFF0
C 0000 000 0 0 000 0011 00 00000 110 03 3FFF0
C 0000 000 0 0 000 1011 00 00000 000 03 3FFF0
C 0000 000 0 0 000 1111 00 00000 110 03 3FFF0
C 0000 000 0 0 000 1001 00 00000 000 03 3FFF0
C 0000 000 0 0 000 0001 00 00000 010 03 3FFF0
C 1100 000 0 0 000 1011 00 00005 000 03 3FFF0
C 0000 000 0 0 000 1011 00 00000 100 03 3FFF0
C 1100 000 0 0 000 0011 00 00020 100 03 3FFF0
C 0000 000 0 0 000 0011 00 00000 000 03 3FFF0
C 1100 000 0 0 000 0011 05 0000F 000 03 3FFF0
C 0000 000 0 0 000 0011 00 00000 110 03 3FFF0
C 0010 000 0 0 000 0011 00 00000 110 03 3FFF0
C 0000 000 0 0 000 0011 00 00000 000 03 3FFF0
W 00 00140011 0
R 00 00140011 0
R 14 00000000 0
C 0010 000 0 0 000 0000 00 00000 000 03 3FFF0
C 0000 000 0 0 000 0000 00 00000 001 03 3FFF0
R 14 00000008 0
C 0010 000 0 0 000 0000 00 00000 001 03 3FFF0
C 0000 000 0 0 000 0000 00 00000 000 03 3FFF0
R 14 00000000 0
W 08 00000000 1
R 08 00140012 0
W 3C 00000001 1
R 3C 00000000 1
R 00 00140011 0
R 04 00000011 0

// ==== testbench/tbVmaUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbVmaUnit
  import vmaPkg::*;
();

  logic clk;
  logic rstN;
  vmaCtlT ctl;
  vmaAddrT ad;
  logic psel;
  logic penable;
  logic pwrite;
  logic [7:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic acRef;
  logic localAcAddr;
  logic match;
  vmaAddrT heldOrPc;

  tbClock uClock (
    .clk  (clk),
    .rstN (rstN)
  );

  vmaUnit #(
    .ApbAddrWidth (8)
  ) DUT (
    .clk         (clk),
    .rstN        (rstN),
    .ctl         (ctl),
    .ad          (ad),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .acRef       (acRef),
    .localAcAddr (localAcAddr),
    .match       (match),
    .heldOrPc    (heldOrPc)
  );

  task automatic reportFail(input string msg);
    $display("Fail @ %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  // One microcode cycle, decodes checked before the clock edge
  task automatic applyCtl(input logic [3:0] mode, input logic [8:0] magic,
                          input logic xe, input logic [1:0] xs, input logic [2:0] pls,
                          input logic [3:0] refs, input vmaAddrT adVal,
                          input logic [2:0] expFlags, input vmaAddrT expHop);
    vmaCtlT c;
    c = '0;
    {c.loadVma, c.useAd, c.vmaInc, c.condMagic} = mode;
    {c.loadPc, c.loadHeld, c.selHeld} = pls;
    {c.vmaExtended, c.vmaFetch, c.pageUebrRef, c.readOrWrite} = refs;
    c.vmaxEn = xe;
    // Magic only matters with condMagic, vmaxSel only with vmaxEn
    c.magic = mode[0] ? magic : 9'($urandom);
    c.vmaxSel = xe ? xs : 2'($urandom);
    @(negedge clk);
    ctl = c;
    ad = adVal;
    #2;
    assert ({acRef, localAcAddr, match} == expFlags) else
      reportFail($sformatf("acRef/localAcAddr/match %b, expected %b",
                           {acRef, localAcAddr, match}, expFlags));
    assert (heldOrPc == expHop) else
      reportFail($sformatf("heldOrPc %h, expected %h", heldOrPc, expHop));
  endtask

  task automatic apbTransfer(input logic write, input logic [7:0] addr,
                             input logic [31:0] value, input logic expErr);
    int waitCount;
    @(negedge clk);
    ctl = '0;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = write ? value : 32'h0;
    @(negedge clk);
    penable = 1'b1;
    #2;
    waitCount = 0;
    while (!pready) begin
      if (waitCount >= 16) begin
        abortRun($sformatf("APB transfer to offset %h never got pready", addr));
      end
      @(negedge clk);
      #2;
      waitCount++;
    end
    assert (pslverr == expErr) else
      reportFail($sformatf("pslverr %b at offset %h, expected %b", pslverr, addr, expErr));
    if (!write) begin
      assert (prdata == value) else
        reportFail($sformatf("read %h at offset %h, expected %h", prdata, addr, value));
    end
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  initial begin
    int fd;
    int code;
    int n;
    int waitCount;
    string line;
    byte op;
    logic [3:0] mode;
    logic [8:0] magic;
    logic xe;
    logic [1:0] xs;
    logic [2:0] pls;
    logic [3:0] refs;
    logic [4:0] adSec;
    logic [17:0] adOff;
    logic [2:0] expFlags;
    logic [4:0] hopSec;
    logic [17:0] hopOff;
    logic [7:0] addr;
    logic [31:0] value;
    logic expErr;

    void'($urandom(48));
    ctl = '0;
    ad = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;

    waitCount = 0;
    while (!rstN) begin
      if (waitCount >= 40) begin
        abortRun("Reset was never released");
      end
      @(posedge clk);
      waitCount++;
    end

    fd = $fopen("testbench/vmaStim.txt", "r");
    if (fd == 0) begin
      abortRun("Cannot open testbench/vmaStim.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      op = line[0];
      if (op == "C") begin
        n = $sscanf(line, "%c %b %h %b %d %b %b %h %h %b %h %h", op, mode, magic, xe,
                    xs, pls, refs, adSec, adOff, expFlags, hopSec, hopOff);
        if (n != 12) begin
          abortRun($sformatf("Bad control line in stimulus file: %s", line));
        end
        applyCtl(mode, magic, xe, xs, pls, refs, {adSec, adOff}, expFlags,
                 {hopSec, hopOff});
      end else if (op == "W" || op == "R") begin
        n = $sscanf(line, "%c %h %h %b", op, addr, value, expErr);
        if (n != 4) begin
          abortRun($sformatf("Bad APB line in stimulus file: %s", line));
        end
        apbTransfer(op == "W", addr, value, expErr);
      end else begin
        abortRun($sformatf("Unknown op in stimulus file: %s", line));
      end
    end
    $fclose(fd);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClock (
  output logic clk,
  output logic rstN
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/vmaUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module vmaUnit
  import vmaPkg::*;
#(
  parameter int ApbAddrWidth = 8
) (
  input  wire logic                    clk,
  input  wire logic                    rstN,
  input  wire vmaCtlT                  ctl,
  input  wire vmaAddrT                 ad,
  input  wire logic                    psel,
  input  wire logic                    penable,
  input  wire logic                    pwrite,
  input  wire logic [ApbAddrWidth-1:0] paddr,
  input  wire logic [ApbDataWidth-1:0] pwdata,
  output logic [ApbDataWidth-1:0]      prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         acRef,
  output logic                         localAcAddr,
  output logic                         match,
  output vmaAddrT                      heldOrPc
);

  vmaStateT state;
  ctxStateT ctx;
  ctxWriteT wr;

  // Previous section feeds the section mux as well as readback
  vmaAddrPath uAddrPath (
    .clk      (clk),
    .rstN     (rstN),
    .ctl      (ctl),
    .ad       (ad),
    .prevSec  (ctx.prevSec),
    .state    (state),
    .heldOrPc (heldOrPc)
  );

  vmaContext uContext (
    .clk  (clk),
    .rstN (rstN),
    .wr   (wr),
    .ctx  (ctx)
  );

  vmaStatusPort #(
    .ApbAddrWidth (ApbAddrWidth)
  ) uStatusPort (
    .clk         (clk),
    .rstN        (rstN),
    .ctl         (ctl),
    .state       (state),
    .ctx         (ctx),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .wr          (wr),
    .acRef       (acRef),
    .localAcAddr (localAcAddr),
    .match       (match)
  );

endmodule

`default_nettype wire

// ==== hdl/vmaStatusPort.sv ====
`timescale 1ns/1ns
`default_nettype none

module vmaStatusPort
  import vmaPkg::*;
#(
  parameter int ApbAddrWidth = 8
) (
  input  wire logic                    clk,
  input  wire logic                    rstN,
  input  wire vmaCtlT                  ctl,
  input  wire vmaStateT                state,
  input  wire ctxStateT                ctx,
  input  wire logic                    psel,
  input  wire logic                    penable,
  input  wire logic                    pwrite,
  input  wire logic [ApbAddrWidth-1:0] paddr,
  input  wire logic [ApbDataWidth-1:0] pwdata,
  output logic [ApbDataWidth-1:0]      prdata,
  output logic                         pready,
  output logic                         pslverr,
  output ctxWriteT                     wr,
  output logic                         acRef,
  output logic                         localAcAddr,
  output logic                         match
);

  logic isLocal;
  logic lowOffZero;
  vmaStatusT status;

  logic setup;
  logic access;
  logic selAdrBrk;
  logic selPrevSec;
  logic selVma;
  logic selPc;
  logic selHeld;
  logic selStatus;
  logic mapped;
  logic writable;
  logic errD;
  logic errQ;
  logic [ApbDataWidth-1:0] readData;

  // Offset bits 18..31 all clear
  assign lowOffZero = state.vma.off[OffWidth-1:4] == '0;
  assign isLocal = !ctl.vmaExtended || ctl.vmaFetch || (state.vma.sec == '0);

  assign acRef = lowOffZero && ctl.pageUebrRef && ctl.readOrWrite && isLocal;
  assign localAcAddr = (state.vma.sec != '0) && isLocal && lowOffZero;
  assign match = ctx.adrBrk == state.vma;

  assign status.acRef = acRef;
  assign status.localAcAddr = localAcAddr;
  assign status.match = match;
  assign status.vmaSecZero = state.vma.sec == '0;
  assign status.pcSecZero = state.pc.sec == '0;
  assign status.prevSecZero = ctx.prevSec == '0;

  // Register decode
  assign selAdrBrk = paddr == ApbAddrWidth'(AdrBrkOff);
  assign selPrevSec = paddr == ApbAddrWidth'(PrevSecOff);
  assign selVma = paddr == ApbAddrWidth'(VmaOff);
  assign selPc = paddr == ApbAddrWidth'(PcOff);
  assign selHeld = paddr == ApbAddrWidth'(HeldOff);
  assign selStatus = paddr == ApbAddrWidth'(StatusOff);

  assign writable = selAdrBrk || selPrevSec;
  assign mapped = writable || selVma || selPc || selHeld || selStatus;

  assign setup = psel && !penable;
  assign access = psel && penable;

  // Error is decided in setup, presented in the access cycle
  assign errD = setup && (pwrite ? !writable : !mapped);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      errQ <= 1'b0;
    end else begin
      errQ <= errD;
    end
  end

  assign wr.wrAdrBrk = access && pwrite && selAdrBrk;
  assign wr.wrPrevSec = access && pwrite && selPrevSec;
  assign wr.wdata = pwdata[VmaWidth-1:0];

  always_comb begin
    readData = '0;
    if (selAdrBrk) begin
      readData = ApbDataWidth'(ctx.adrBrk);
    end else if (selPrevSec) begin
      readData = ApbDataWidth'(ctx.prevSec);
    end else if (selVma) begin
      readData = ApbDataWidth'(state.vma);
    end else if (selPc) begin
      readData = ApbDataWidth'(state.pc);
    end else if (selHeld) begin
      readData = ApbDataWidth'(state.held);
    end else if (selStatus) begin
      readData = ApbDataWidth'(status);
    end
  end

  // Read data only while a read is in its access cycle
  assign prdata = (access && !pwrite) ? readData : '0;
  assign pready = 1'b1;
  assign pslverr = errQ;

endmodule

`default_nettype wire

// ==== hdl/vmaContext.sv ====
`timescale 1ns/1ns
`default_nettype none

module vmaContext
  import vmaPkg::*;
(
  input  wire logic     clk,
  input  wire logic     rstN,
  input  wire ctxWriteT wr,
  output ctxStateT      ctx
);

  vmaAddrT adrBrkQ;
  vmaSecT prevSecQ;

  // Address break, full section and offset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      adrBrkQ <= '0;
    end else if (wr.wrAdrBrk) begin
      adrBrkQ <= vmaAddrT'(wr.wdata);
    end
  end

  // Previous context section, low bits of the write data
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      prevSecQ <= '0;
    end else if (wr.wrPrevSec) begin
      prevSecQ <= wr.wdata[SecWidth-1:0];
    end
  end

  assign ctx.adrBrk = adrBrkQ;
  assign ctx.prevSec = prevSecQ;

endmodule

`default_nettype wire

// ==== hdl/vmaAddrPath.sv ====
`timescale 1ns/1ns
`default_nettype none

module vmaAddrPath
  import vmaPkg::*;
(
  input  wire logic    clk,
  input  wire logic    rstN,
  input  wire vmaCtlT  ctl,
  input  wire vmaAddrT ad,
  input  wire vmaSecT  prevSec,
  output vmaStateT     state,
  output vmaAddrT      heldOrPc
);

  vmaAddrT vmaQ;
  vmaAddrT pcQ;
  vmaAddrT heldQ;

  logic [OffWidth-1:0] adderOff;
  logic [OffWidth-1:0] loadOff;
  logic [OffWidth-1:0] nextOff;
  vmaSecT nextSec;

  // Magic-number adder, PC offset plus magic or plus one
  always_comb begin
    if (ctl.condMagic) begin
      adderOff = pcQ.off + OffWidth'(ctl.magic);
    end else if (ctl.vmaInc) begin
      adderOff = pcQ.off + OffWidth'(1);
    end else begin
      adderOff = pcQ.off;
    end
  end

  // Data bus or adder
  always_comb begin
    if (ctl.useAd) begin
      loadOff = ad.off;
    end else begin
      loadOff = adderOff;
    end
  end

  // Load, count or hold
  always_comb begin
    if (ctl.loadVma) begin
      nextOff = loadOff;
    end else if (ctl.vmaInc) begin
      nextOff = vmaQ.off + OffWidth'(1);
    end else begin
      nextOff = vmaQ.off;
    end
  end

  // Extended-section source mux
  always_comb begin
    if (ctl.vmaxEn) begin
      case (ctl.vmaxSel)
        2'd0: nextSec = vmaQ.sec;
        2'd1: nextSec = pcQ.sec;
        2'd2: nextSec = prevSec;
        default: nextSec = ad.sec;
      endcase
    end else if (ctl.useAd) begin
      nextSec = ad.sec;
    end else begin
      nextSec = vmaQ.sec;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      vmaQ <= '0;
    end else begin
      vmaQ.sec <= nextSec;
      vmaQ.off <= nextOff;
    end
  end

  // PC and held both capture the current VMA
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcQ <= '0;
    end else if (ctl.loadPc) begin
      pcQ <= vmaQ;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      heldQ <= '0;
    end else if (ctl.loadHeld) begin
      heldQ <= vmaQ;
    end
  end

  always_comb begin
    if (ctl.selHeld) begin
      heldOrPc = heldQ;
    end else begin
      heldOrPc = pcQ;
    end
  end

  assign state.vma = vmaQ;
  assign state.pc = pcQ;
  assign state.held = heldQ;

endmodule

`default_nettype wire

// ==== hdl/vmaPkg.sv ====
`default_nettype none

package vmaPkg;

  localparam int SecWidth = 5;
  localparam int OffWidth = 18;
  localparam int VmaWidth = SecWidth + OffWidth;
  localparam int MagicWidth = 9;
  localparam int ApbDataWidth = 32;

  typedef logic [SecWidth-1:0] vmaSecT;

  // Bits 13..17 section, 18..35 offset
  typedef struct packed {
    vmaSecT sec;
    logic [OffWidth-1:0] off;
  } vmaAddrT;

  typedef struct packed {
    logic loadVma;
    logic useAd;
    logic vmaInc;
    logic condMagic;
    logic [MagicWidth-1:0] magic;
    logic vmaxEn;
    logic [1:0] vmaxSel;
    logic loadPc;
    logic loadHeld;
    logic selHeld;
    logic vmaExtended;
    logic vmaFetch;
    logic pageUebrRef;
    logic readOrWrite;
  } vmaCtlT;

  typedef struct packed {
    vmaAddrT vma;
    vmaAddrT pc;
    vmaAddrT held;
  } vmaStateT;

  typedef struct packed {
    vmaAddrT adrBrk;
    vmaSecT prevSec;
  } ctxStateT;

  typedef struct packed {
    logic wrAdrBrk;
    logic wrPrevSec;
    logic [VmaWidth-1:0] wdata;
  } ctxWriteT;

  // STATUS readback, acRef is the top bit
  typedef struct packed {
    logic acRef;
    logic localAcAddr;
    logic match;
    logic vmaSecZero;
    logic pcSecZero;
    logic prevSecZero;
  } vmaStatusT;

  localparam logic [7:0] AdrBrkOff = 8'h00;
  localparam logic [7:0] PrevSecOff = 8'h04;
  localparam logic [7:0] VmaOff = 8'h08;
  localparam logic [7:0] PcOff = 8'h0C;
  localparam logic [7:0] HeldOff = 8'h10;
  localparam logic [7:0] StatusOff = 8'h14;

endpackage

`default_nettype wire
